//--- logic/pipe_pkg.sv
package pipe_pkg;

    // ############################################################
    // instruction format
    // ############################################################

    localparam int reg_w   = 2;
    localparam int instr_w = 16;
    localparam int opc_w   = 4;
    localparam int imm6_w  = 6;
    localparam int imm8_w  = 8;

    // field positions, the opcode sits in the top nibble
    localparam int op_lsb = 12;
    localparam int rs_lsb = 10;
    localparam int rt_lsb = 8;
    localparam int rd_lsb = 6;

    // load-immediate always lands in this register
    localparam logic [reg_w-1:0] two_reg = 2'd2;

    // ############################################################
    // enums
    // ############################################################

    typedef enum logic [opc_w-1:0] {
        op_nop  = 4'h0,
        op_add  = 4'h1,
        op_sub  = 4'h2,
        op_and  = 4'h3,
        op_or   = 4'h4,
        op_addi = 4'h5,
        op_lw   = 4'h6,
        op_sw   = 4'h7,
        op_li   = 4'h8,
        op_halt = 4'hf
    } opcode_e;

    typedef enum logic [1:0] {
        wr_rd  = 2'b00,
        wr_rt  = 2'b01,
        wr_two = 2'b10
    } wr_dest_e;

    typedef enum logic [1:0] {
        fwd_none = 2'b00,
        fwd_wb   = 2'b01,
        fwd_mem  = 2'b10
    } fwd_sel_e;

endpackage

//--- logic/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage import pipe_pkg::*; #(
    parameter int data_w = 8
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               stall,
    input  logic               freeze,
    input  logic [instr_w-1:0] imem_data,
    output logic [data_w-1:0]  imem_addr,
    output logic [instr_w-1:0] ifid_instr,
    output logic               ifid_valid
);

    logic [data_w-1:0] pc;
    logic              halt_seen;
    logic              fetch_halt;

    assign imem_addr  = pc;
    assign fetch_halt = (opcode_e'(imem_data[op_lsb +: opc_w]) == op_halt);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc         <= '0;
            halt_seen  <= 1'b0;
            ifid_instr <= '0;
            ifid_valid <= 1'b0;
        end else if (!stall && !freeze) begin
            if (halt_seen) begin
                // all zeros decodes as nop
                ifid_instr <= '0;
                ifid_valid <= 1'b0;
            end else begin
                ifid_instr <= imem_data;
                ifid_valid <= 1'b1;
                halt_seen  <= fetch_halt;
                if (!fetch_halt) begin
                    pc <= pc + 1'b1;
                end
            end
        end
    end

endmodule

//--- logic/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import pipe_pkg::*; #(
    parameter int data_w = 8
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               freeze,
    input  logic [instr_w-1:0] ifid_instr,
    input  logic               ifid_valid,
    input  logic               wb_en,
    input  logic [reg_w-1:0]   wb_idx,
    input  logic [data_w-1:0]  wb_val,
    output logic               stall,
    output logic               idex_valid,
    output opcode_e            idex_op,
    output logic               idex_reg_write,
    output wr_dest_e           idex_wr_dest,
    output logic [reg_w-1:0]   idex_rs,
    output logic [reg_w-1:0]   idex_rt,
    output logic [reg_w-1:0]   idex_rd,
    output logic [data_w-1:0]  idex_a,
    output logic [data_w-1:0]  idex_b,
    output logic [data_w-1:0]  idex_imm
);

    logic [data_w-1:0]        regs [2**reg_w];
    opcode_e                  op;
    logic [reg_w-1:0]         rs;
    logic [reg_w-1:0]         rt;
    logic [reg_w-1:0]         rd;
    logic signed [imm6_w-1:0] imm6;
    logic signed [imm8_w-1:0] imm8;
    logic [data_w-1:0]        imm;
    logic                     reg_write;
    wr_dest_e                 wr_dest;
    logic                     reads_rt;
    logic [data_w-1:0]        rs_val;
    logic [data_w-1:0]        rt_val;

    assign op   = opcode_e'(ifid_instr[op_lsb +: opc_w]);
    assign rs   = ifid_instr[rs_lsb +: reg_w];
    assign rt   = ifid_instr[rt_lsb +: reg_w];
    assign rd   = ifid_instr[rd_lsb +: reg_w];
    assign imm6 = ifid_instr[imm6_w-1:0];
    assign imm8 = ifid_instr[imm8_w-1:0];
    assign imm  = (op == op_li) ? data_w'(imm8) : data_w'(imm6);

    always_comb begin
        reg_write = 1'b0;
        wr_dest   = wr_rd;
        reads_rt  = 1'b0;
        case (op)
            op_add, op_sub, op_and, op_or: begin
                reg_write = 1'b1;
                reads_rt  = 1'b1;
            end
            op_addi, op_lw: begin
                reg_write = 1'b1;
                wr_dest   = wr_rt;
            end
            op_sw: begin
                reads_rt = 1'b1;
            end
            op_li: begin
                reg_write = 1'b1;
                wr_dest   = wr_two;
            end
            default: begin
            end
        endcase
    end

    // ############################################################
    // register file, a same-cycle write is seen by the read
    // ############################################################

    always_ff @(posedge clk) begin
        if (wb_en) begin
            regs[wb_idx] <= wb_val;
        end
    end

    assign rs_val = (wb_en && wb_idx == rs) ? wb_val : regs[rs];
    assign rt_val = (wb_en && wb_idx == rt) ? wb_val : regs[rt];

    // the loaded value is not ready until it sits in MEM/WB
    assign stall = ifid_valid && idex_valid && (idex_op == op_lw) &&
                   ((idex_rt == rs) || (reads_rt && idex_rt == rt));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idex_valid     <= 1'b0;
            idex_op        <= op_nop;
            idex_reg_write <= 1'b0;
            idex_wr_dest   <= wr_rd;
        end else if (!freeze) begin
            idex_valid     <= ifid_valid && !stall;
            idex_op        <= op;
            idex_reg_write <= reg_write && !stall;
            idex_wr_dest   <= wr_dest;
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze) begin
            idex_rs  <= rs;
            idex_rt  <= rt;
            idex_rd  <= rd;
            idex_a   <= rs_val;
            idex_b   <= rt_val;
            idex_imm <= imm;
        end
    end

endmodule

//--- logic/forwarding_unit.sv
`timescale 1ns/1ps

module forwarding_unit import pipe_pkg::*; (
    input  logic             exmem_valid,
    input  logic             exmem_reg_write,
    input  wr_dest_e         exmem_wr_dest,
    input  logic [reg_w-1:0] exmem_rd,
    input  logic [reg_w-1:0] exmem_rt,
    input  logic             memwb_valid,
    input  logic             memwb_reg_write,
    input  wr_dest_e         memwb_wr_dest,
    input  logic [reg_w-1:0] memwb_rd,
    input  logic [reg_w-1:0] memwb_rt,
    input  logic [reg_w-1:0] idex_rs,
    input  logic [reg_w-1:0] idex_rt,
    output fwd_sel_e         forward_a,
    output fwd_sel_e         forward_b
);

    logic [reg_w-1:0] exmem_dst;
    logic [reg_w-1:0] memwb_dst;
    logic             exmem_live;
    logic             memwb_live;

    function automatic logic [reg_w-1:0] dest_idx(
        input wr_dest_e         dest,
        input logic [reg_w-1:0] rd,
        input logic [reg_w-1:0] rt
    );
        case (dest)
            wr_rt:   return rt;
            wr_two:  return two_reg;
            default: return rd;
        endcase
    endfunction

    // the younger EX/MEM entry wins, a miss there still lets MEM/WB through
    function automatic fwd_sel_e pick(input logic [reg_w-1:0] src);
        if (exmem_live && exmem_dst == src) begin
            return fwd_mem;
        end
        if (memwb_live && memwb_dst == src) begin
            return fwd_wb;
        end
        return fwd_none;
    endfunction

    assign exmem_dst  = dest_idx(exmem_wr_dest, exmem_rd, exmem_rt);
    assign memwb_dst  = dest_idx(memwb_wr_dest, memwb_rd, memwb_rt);
    assign exmem_live = exmem_valid && exmem_reg_write;
    assign memwb_live = memwb_valid && memwb_reg_write;

    always_comb begin
        forward_a = pick(idex_rs);
        forward_b = pick(idex_rt);
    end

endmodule

//--- logic/execute_stage.sv
`timescale 1ns/1ps

module execute_stage import pipe_pkg::*; #(
    parameter int data_w = 8
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              freeze,
    input  logic              idex_valid,
    input  opcode_e           idex_op,
    input  logic              idex_reg_write,
    input  wr_dest_e          idex_wr_dest,
    input  logic [reg_w-1:0]  idex_rt,
    input  logic [reg_w-1:0]  idex_rd,
    input  logic [data_w-1:0] idex_a,
    input  logic [data_w-1:0] idex_b,
    input  logic [data_w-1:0] idex_imm,
    input  fwd_sel_e          forward_a,
    input  fwd_sel_e          forward_b,
    input  logic [data_w-1:0] memwb_result,
    output logic              exmem_valid,
    output opcode_e           exmem_op,
    output logic              exmem_reg_write,
    output wr_dest_e          exmem_wr_dest,
    output logic [reg_w-1:0]  exmem_rd,
    output logic [reg_w-1:0]  exmem_rt,
    output logic [data_w-1:0] exmem_result,
    output logic [data_w-1:0] exmem_store_data
);

    logic [data_w-1:0] op_a;
    logic [data_w-1:0] op_b;
    logic [data_w-1:0] alu_out;

    always_comb begin
        case (forward_a)
            fwd_mem: op_a = exmem_result;
            fwd_wb:  op_a = memwb_result;
            default: op_a = idex_a;
        endcase
        case (forward_b)
            fwd_mem: op_b = exmem_result;
            fwd_wb:  op_b = memwb_result;
            default: op_b = idex_b;
        endcase
    end

    // loads and stores reuse the adder for rs + imm
    always_comb begin
        case (idex_op)
            op_add:                alu_out = op_a + op_b;
            op_sub:                alu_out = op_a - op_b;
            op_and:                alu_out = op_a & op_b;
            op_or:                 alu_out = op_a | op_b;
            op_addi, op_lw, op_sw: alu_out = op_a + idex_imm;
            op_li:                 alu_out = idex_imm;
            default:               alu_out = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exmem_valid     <= 1'b0;
            exmem_op        <= op_nop;
            exmem_reg_write <= 1'b0;
            exmem_wr_dest   <= wr_rd;
        end else if (!freeze) begin
            exmem_valid     <= idex_valid;
            exmem_op        <= idex_op;
            exmem_reg_write <= idex_reg_write;
            exmem_wr_dest   <= idex_wr_dest;
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze) begin
            exmem_rd         <= idex_rd;
            exmem_rt         <= idex_rt;
            exmem_result     <= alu_out;
            exmem_store_data <= op_b;
        end
    end

endmodule

//--- logic/memory_stage.sv
`timescale 1ns/1ps

module memory_stage import pipe_pkg::*; #(
    parameter int data_w = 8
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              exmem_valid,
    input  opcode_e           exmem_op,
    input  logic              exmem_reg_write,
    input  wr_dest_e          exmem_wr_dest,
    input  logic [reg_w-1:0]  exmem_rd,
    input  logic [reg_w-1:0]  exmem_rt,
    input  logic [data_w-1:0] exmem_result,
    input  logic [data_w-1:0] exmem_store_data,
    input  logic [data_w-1:0] wb_dat_r,
    input  logic              wb_ack,
    output logic              wb_cyc,
    output logic              wb_stb,
    output logic              wb_we,
    output logic [data_w-1:0] wb_adr,
    output logic [data_w-1:0] wb_dat_w,
    output logic              freeze,
    output logic              memwb_valid,
    output logic              memwb_reg_write,
    output wr_dest_e          memwb_wr_dest,
    output logic [reg_w-1:0]  memwb_rd,
    output logic [reg_w-1:0]  memwb_rt,
    output logic [data_w-1:0] memwb_result,
    output logic              halted
);

    typedef enum logic {idle, busy} mem_state_e;

    mem_state_e state;
    logic       mem_req;
    logic       done;

    assign mem_req = exmem_valid && (exmem_op == op_lw || exmem_op == op_sw);
    assign done    = (state == busy) && wb_ack;

    // hold everything from the issue cycle until ack comes back
    assign freeze = mem_req && !done;

    // ############################################################
    // Wishbone classic master
    // ############################################################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= idle;
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            wb_we  <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (mem_req) begin
                        state  <= busy;
                        wb_cyc <= 1'b1;
                        wb_stb <= 1'b1;
                        wb_we  <= (exmem_op == op_sw);
                    end
                end
                default: begin
                    if (wb_ack) begin
                        state  <= idle;
                        wb_cyc <= 1'b0;
                        wb_stb <= 1'b0;
                        wb_we  <= 1'b0;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == idle && mem_req) begin
            wb_adr   <= exmem_result;
            wb_dat_w <= exmem_store_data;
        end
    end

    // ############################################################
    // MEM/WB latch
    // ############################################################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            memwb_valid     <= 1'b0;
            memwb_reg_write <= 1'b0;
            memwb_wr_dest   <= wr_rd;
            halted          <= 1'b0;
        end else if (!freeze) begin
            memwb_valid     <= exmem_valid;
            memwb_reg_write <= exmem_reg_write;
            memwb_wr_dest   <= exmem_wr_dest;
            if (exmem_valid && exmem_op == op_halt) begin
                halted <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze) begin
            memwb_rd     <= exmem_rd;
            memwb_rt     <= exmem_rt;
            memwb_result <= (exmem_op == op_lw) ? wb_dat_r : exmem_result;
        end
    end

endmodule

//--- logic/pipe_core.sv
`timescale 1ns/1ps

module pipe_core import pipe_pkg::*; #(
    parameter int data_w = 8
) (
    input  logic               clk,
    input  logic               rst_n,
    output logic [data_w-1:0]  imem_addr,
    input  logic [instr_w-1:0] imem_data,
    output logic               wb_cyc,
    output logic               wb_stb,
    output logic               wb_we,
    output logic [data_w-1:0]  wb_adr,
    output logic [data_w-1:0]  wb_dat_w,
    input  logic [data_w-1:0]  wb_dat_r,
    input  logic               wb_ack,
    output logic               halted
);

    logic               stall;
    logic               freeze;
    logic [instr_w-1:0] ifid_instr;
    logic               ifid_valid;

    logic               idex_valid;
    opcode_e            idex_op;
    logic               idex_reg_write;
    wr_dest_e           idex_wr_dest;
    logic [reg_w-1:0]   idex_rs;
    logic [reg_w-1:0]   idex_rt;
    logic [reg_w-1:0]   idex_rd;
    logic [data_w-1:0]  idex_a;
    logic [data_w-1:0]  idex_b;
    logic [data_w-1:0]  idex_imm;
    fwd_sel_e           forward_a;
    fwd_sel_e           forward_b;

    logic               exmem_valid;
    opcode_e            exmem_op;
    logic               exmem_reg_write;
    wr_dest_e           exmem_wr_dest;
    logic [reg_w-1:0]   exmem_rd;
    logic [reg_w-1:0]   exmem_rt;
    logic [data_w-1:0]  exmem_result;
    logic [data_w-1:0]  exmem_store_data;

    logic               memwb_valid;
    logic               memwb_reg_write;
    wr_dest_e           memwb_wr_dest;
    logic [reg_w-1:0]   memwb_rd;
    logic [reg_w-1:0]   memwb_rt;
    logic [data_w-1:0]  memwb_result;

    logic               wb_en;
    logic [reg_w-1:0]   wb_idx;
    logic [data_w-1:0]  wb_val;

    // write-back bus into the register file
    assign wb_en  = memwb_valid && memwb_reg_write;
    assign wb_idx = (memwb_wr_dest == wr_two) ? two_reg :
                    (memwb_wr_dest == wr_rt)  ? memwb_rt : memwb_rd;
    assign wb_val = memwb_result;

    fetch_stage #(.data_w(data_w)) fetch_i (.*);

    decode_stage #(.data_w(data_w)) decode_i (.*);

    forwarding_unit fwd_i (.*);

    execute_stage #(.data_w(data_w)) execute_i (.*);

    memory_stage #(.data_w(data_w)) memory_i (.*);

endmodule

//--- test/pipe_core_tb.sv
`timescale 1ns/1ps

module pipe_core_tb import pipe_pkg::*;;

    localparam int data_w     = 8;
    localparam int num_tests  = 5;
    localparam int rom_depth  = 16;
    localparam int max_stores = 8;
    localparam int halt_limit = 500;

    logic               clk;
    logic               rst_n;
    logic [data_w-1:0]  imem_addr;
    logic [instr_w-1:0] imem_data;
    logic               wb_cyc;
    logic               wb_stb;
    logic               wb_we;
    logic [data_w-1:0]  wb_adr;
    logic [data_w-1:0]  wb_dat_w;
    logic [data_w-1:0]  wb_dat_r = '0;
    logic               wb_ack = 1'b0;
    logic               halted;

    logic [instr_w-1:0] rom [rom_depth];
    logic [data_w-1:0]  dmem [2**data_w];
    logic [data_w-1:0]  seen_adr [$];
    logic [data_w-1:0]  seen_dat [$];
    logic [31:0]        lcg_state = 32'h4f90_a61e;
    logic [31:0]        rand_word;
    logic               acc_open = 1'b0;
    int                 wait_left = 0;
    string              cur_name = "";

    // one row of the program table per test
    string              test_name [num_tests];
    logic [instr_w-1:0] prog [num_tests][rom_depth];
    int                 prog_len [num_tests];
    int                 exp_cnt [num_tests];
    logic [data_w-1:0]  exp_adr [num_tests][max_stores];
    logic [data_w-1:0]  exp_dat [num_tests][max_stores];

    pipe_core #(.data_w(data_w)) dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .halted    (halted)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // addresses past the ROM read as nop
    assign imem_data = (imem_addr < rom_depth) ? rom[imem_addr[3:0]] : '0;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [instr_w-1:0] alu_rr(input opcode_e op, input int rs,
                                                  input int rt, input int rd);
        return {op, 2'(rs), 2'(rt), 2'(rd), 6'd0};
    endfunction

    function automatic logic [instr_w-1:0] imm_form(input opcode_e op, input int rs,
                                                    input int rt, input int imm);
        return {op, 2'(rs), 2'(rt), 2'd0, 6'(imm)};
    endfunction

    function automatic logic [instr_w-1:0] li_word(input int imm);
        return {op_li, 4'd0, 8'(imm)};
    endfunction

    task automatic stop_run();
        $display("Regression failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_data(input string name, input string what,
                              input logic [data_w-1:0] exp, input logic [data_w-1:0] act);
        if (act !== exp) begin
            $display("ERR %s %s: expected %0d, actual %0d", name, what, exp, act);
            stop_run();
        end
    endtask

    task automatic check_addr(input string name, input string what,
                              input logic [data_w-1:0] exp, input logic [data_w-1:0] act);
        if (act !== exp) begin
            $display("ERR %s %s: expected 0x%0h, actual 0x%0h", name, what, exp, act);
            stop_run();
        end
    endtask

    task automatic add_instr(input int t, input logic [instr_w-1:0] word);
        prog[t][prog_len[t]] = word;
        prog_len[t] = prog_len[t] + 1;
    endtask

    task automatic add_store(input int t, input int adr, input int dat);
        exp_adr[t][exp_cnt[t]] = data_w'(adr);
        exp_dat[t][exp_cnt[t]] = data_w'(dat);
        exp_cnt[t] = exp_cnt[t] + 1;
    endtask

    // ############################################################
    // program table
    // ############################################################

    task automatic build_table();
        for (int t = 0; t < num_tests; t++) begin
            prog_len[t] = 0;
            exp_cnt[t] = 0;
            for (int i = 0; i < rom_depth; i++) begin
                prog[t][i] = '0;
            end
        end

        // back-to-back dependents each take the EX/MEM result
        test_name[0] = "ex_mem_forward";
        add_instr(0, li_word(10));
        add_instr(0, imm_form(op_addi, 2, 1, 5));
        add_instr(0, alu_rr(op_add, 1, 2, 3));
        add_instr(0, imm_form(op_sw, 2, 3, 3));
        add_instr(0, alu_rr(op_sub, 3, 1, 0));
        add_instr(0, imm_form(op_sw, 1, 0, 0));
        add_instr(0, {op_halt, 12'd0});
        add_store(0, 13, 25);
        add_store(0, 15, 10);

        // li 7 must beat li 3, and addi r1 must pass the non-matching li 40 in EX/MEM
        test_name[1] = "mem_wb_priority";
        add_instr(1, li_word(3));
        add_instr(1, li_word(7));
        add_instr(1, imm_form(op_addi, 2, 1, 1));
        add_instr(1, li_word(40));
        add_instr(1, imm_form(op_addi, 1, 0, 2));
        add_instr(1, alu_rr(op_add, 2, 0, 3));
        add_instr(1, imm_form(op_sw, 1, 3, 0));
        add_instr(1, imm_form(op_sw, 0, 2, 4));
        add_instr(1, {op_halt, 12'd0});
        add_store(1, 8, 50);
        add_store(1, 14, 40);

        test_name[2] = "dest_kinds";
        add_instr(2, li_word(6));
        add_instr(2, alu_rr(op_add, 2, 2, 1));
        add_instr(2, imm_form(op_addi, 1, 0, 3));
        add_instr(2, alu_rr(op_sub, 0, 1, 3));
        add_instr(2, imm_form(op_addi, 3, 1, 1));
        add_instr(2, alu_rr(op_or, 3, 1, 0));
        add_instr(2, imm_form(op_sw, 2, 0, 0));
        add_instr(2, imm_form(op_sw, 3, 1, 8));
        add_instr(2, {op_halt, 12'd0});
        add_store(2, 6, 7);
        add_store(2, 11, 4);

        // the loaded register is used once as rs and once as rt
        test_name[3] = "load_use";
        add_instr(3, li_word(9));
        add_instr(3, imm_form(op_addi, 2, 1, 20));
        add_instr(3, imm_form(op_sw, 2, 1, 1));
        add_instr(3, imm_form(op_lw, 2, 3, 1));
        add_instr(3, alu_rr(op_add, 3, 2, 0));
        add_instr(3, imm_form(op_sw, 2, 0, 2));
        add_instr(3, imm_form(op_lw, 2, 1, 2));
        add_instr(3, alu_rr(op_sub, 2, 1, 3));
        add_instr(3, imm_form(op_sw, 2, 3, 3));
        add_instr(3, {op_halt, 12'd0});
        add_store(3, 10, 29);
        add_store(3, 11, 38);
        add_store(3, 12, 227);

        test_name[4] = "wait_states";
        add_instr(4, li_word(1));
        add_instr(4, imm_form(op_addi, 2, 0, 1));
        add_instr(4, imm_form(op_sw, 2, 0, 0));
        add_instr(4, alu_rr(op_add, 0, 0, 1));
        add_instr(4, imm_form(op_sw, 0, 1, 0));
        add_instr(4, alu_rr(op_add, 1, 1, 3));
        add_instr(4, imm_form(op_sw, 1, 3, 0));
        add_instr(4, alu_rr(op_sub, 3, 0, 0));
        add_instr(4, imm_form(op_sw, 3, 0, 0));
        add_instr(4, imm_form(op_lw, 3, 1, 0));
        add_instr(4, imm_form(op_sw, 0, 1, 1));
        add_instr(4, {op_halt, 12'd0});
        add_store(4, 1, 2);
        add_store(4, 2, 4);
        add_store(4, 4, 8);
        add_store(4, 8, 6);
        add_store(4, 7, 6);
    endtask

    // ############################################################
    // Wishbone data memory with 0 to 3 wait states per access
    // ############################################################

    always @(negedge clk) begin
        if (!rst_n) begin
            wb_ack   = 1'b0;
            acc_open = 1'b0;
        end else if (wb_ack) begin
            wb_ack = 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (!acc_open) begin
                acc_open  = 1'b1;
                rand_word = next_rand();
                wait_left = rand_word[17:16];
            end
            if (wait_left != 0) begin
                wait_left = wait_left - 1;
            end else if (wb_we && halted) begin
                $display("store to 0x%0h came after halted rose in test %s", wb_adr, cur_name);
                stop_run();
            end else begin
                acc_open = 1'b0;
                wb_ack   = 1'b1;
                if (wb_we) begin
                    dmem[wb_adr] = wb_dat_w;
                    seen_adr.push_back(wb_adr);
                    seen_dat.push_back(wb_dat_w);
                end else begin
                    wb_dat_r = dmem[wb_adr];
                end
            end
        end
    end

    task automatic wait_halted();
        int cycles;
        cycles = 0;
        while (!halted && cycles < halt_limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted) begin
            $display("timeout: halted did not rise within %0d cycles in test %s",
                     halt_limit, cur_name);
            stop_run();
        end
    endtask

    task automatic run_test(input int t);
        cur_name = test_name[t];
        @(negedge clk);
        rst_n = 1'b0;
        for (int i = 0; i < rom_depth; i++) begin
            rom[i] = prog[t][i];
        end
        for (int a = 0; a < 2**data_w; a++) begin
            dmem[a] = data_w'(a * 37 + 11);
        end
        seen_adr.delete();
        seen_dat.delete();
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        wait_halted();
        // the PC stops on the halt, which is the last word of every program
        check_addr(cur_name, "halt pc", data_w'(prog_len[t] - 1), imem_addr);
        check_data(cur_name, "store count", data_w'(exp_cnt[t]), data_w'(seen_adr.size()));
        for (int i = 0; i < exp_cnt[t]; i++) begin
            check_addr(cur_name, "store address", exp_adr[t][i], seen_adr[i]);
            check_data(cur_name, "store data", exp_dat[t][i], seen_dat[i]);
        end
    endtask

    initial begin
        rst_n = 1'b0;
        for (int i = 0; i < rom_depth; i++) begin
            rom[i] = '0;
        end
        build_table();
        for (int t = 0; t < num_tests; t++) begin
            run_test(t);
        end
        $display("Regression passed");
        $finish;
    end

endmodule

//--- verilog.f
logic/pipe_pkg.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/forwarding_unit.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/pipe_core.sv
test/pipe_core_tb.sv
